/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_issue_stage
OBJ_DIR   ?= obj_dir
FILELIST  ?= project.f
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "variables: VERILATOR TOP OBJ_DIR FILELIST VFLAGS"

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

test: $(OBJ_DIR)/V$(TOP)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx 'PASS: all tests'

clean:
	rm -rf $(OBJ_DIR)

/* include/issue_defines.svh */
`ifndef ISSUE_DEFINES_SVH
`define ISSUE_DEFINES_SVH

// operand and immediate width
`define ISSUE_WORD_WIDTH 32

`define ISSUE_PC_WIDTH 32

// tag width is log2 of this
`define ISSUE_ROB_DEPTH 16

// reservation entries per queue
`define ISSUE_ALU_QUEUE_DEPTH 4
`define ISSUE_MEM_QUEUE_DEPTH 4

`endif

/* logic/dispatch_steer.sv */
module dispatch_steer (
    input  issue_types_pkg::dispatch_t dispatch,
    input  logic                       alu_full,
    input  logic                       mem_full,
    output logic                       alu_push,
    output logic                       mem_push,
    output issue_types_pkg::dispatch_t entry,
    output logic                       stall
);
    import issue_ops_pkg::*;
    import issue_types_pkg::*;

    logic alu_valid;
    logic mem_valid;

    // rob forward wins over gpr, pending only when rat points at an unfinished rob entry
    function automatic dispatch_src_t resolve(dispatch_src_t d);
        dispatch_src_t r;
        r           = d;
        r.rat_valid = d.rat_valid && !d.rob_valid;
        r.gpr_value = d.rob_valid ? d.rob_value : d.gpr_value;
        r.rob_valid = 1'b0;
        r.rob_value = r.gpr_value;
        return r;
    endfunction

    always_comb begin
        entry      = dispatch;
        entry.src1 = resolve(dispatch.src1);
        entry.src2 = resolve(dispatch.src2);
    end

    assign alu_valid = dispatch.alu_op != ALU_OP_NOP;
    assign mem_valid = dispatch.mem_op != MEM_OP_NOP;

    assign alu_push = alu_valid && !alu_full;
    assign mem_push = mem_valid && !mem_full;

    // a push freed by this cycle's issue does not count
    assign stall = (alu_valid && alu_full) || (mem_valid && mem_full);

    always_comb begin
        if (!$isunknown({dispatch.alu_op, dispatch.mem_op})) begin
            assert (!(alu_valid && mem_valid))
                else $error("dispatch carries both an alu op and a memory op");
        end
    end

endmodule

/* logic/issue_ops_pkg.sv */
package issue_ops_pkg;

    // base integer ops, then the immediate forms
    typedef enum logic [4:0] {
        ALU_OP_NOP,
        ALU_OP_ADD,
        ALU_OP_SUB,
        ALU_OP_AND,
        ALU_OP_OR,
        ALU_OP_XOR,
        ALU_OP_SLL,
        ALU_OP_SRL,
        ALU_OP_SRA,
        ALU_OP_SLT,
        ALU_OP_SLTU,
        ALU_OP_LUI,
        ALU_OP_AUIPC,
        ALU_OP_ADDI,
        ALU_OP_SLTI,
        ALU_OP_SLTIU,
        ALU_OP_ANDI,
        ALU_OP_ORI,
        ALU_OP_XORI,
        ALU_OP_SLLI,
        ALU_OP_SRLI,
        ALU_OP_SRAI
    } alu_op_e;

    typedef enum logic [3:0] {
        MEM_OP_NOP,
        MEM_OP_LB,
        MEM_OP_LH,
        MEM_OP_LW,
        MEM_OP_LBU,
        MEM_OP_LHU,
        MEM_OP_SB,
        MEM_OP_SH,
        MEM_OP_SW
    } mem_op_e;

endpackage

/* logic/issue_queue_ino.sv */
`include "issue_defines.svh"

module issue_queue_ino (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        flush,
    input  logic                        push,
    input  issue_types_pkg::dispatch_t  entry,
    input  issue_types_pkg::wb_bus_t    wb_alu,
    input  issue_types_pkg::wb_bus_t    wb_load,
    input  logic                        mem_ready,
    output logic                        full,
    output issue_types_pkg::mem_issue_t issue
);
    import issue_ops_pkg::*;
    import issue_types_pkg::*;

    localparam int DEPTH = `ISSUE_MEM_QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    typedef struct packed {
        mem_op_e  mem_op;
        pc_t      pc;
        word_t    imm;
        rob_tag_t dst_tag;
        src_t     src1;
        src_t     src2;
    } mem_slot_t;

    mem_slot_t        slots [DEPTH];
    mem_slot_t        incoming;
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic             empty;
    logic             head_fire;

    queue_pointers #(
        .DEPTH (DEPTH)
    ) u_queue_pointers (
        .clk   (clk),
        .reset (reset),
        .flush (flush),
        .push  (push),
        .pop   (head_fire),
        .head  (head),
        .tail  (tail),
        .full  (full),
        .empty (empty)
    );

    always_comb begin
        incoming.mem_op  = entry.mem_op;
        incoming.pc      = entry.pc;
        incoming.imm     = entry.imm;
        incoming.dst_tag = entry.dst_tag;
        incoming.src1    = wake_src(resolved_src(entry.src1), wb_alu, wb_load);
        incoming.src2    = wake_src(resolved_src(entry.src2), wb_alu, wb_load);
    end

    // only the head may leave, younger ready entries wait behind it
    assign head_fire = !empty && mem_ready
                     && !slots[head].src1.pending && !slots[head].src2.pending;

    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            if (push && tail == PTR_W'(i)) begin
                slots[i] <= incoming;
            end else begin
                slots[i].src1 <= wake_src(slots[i].src1, wb_alu, wb_load);
                slots[i].src2 <= wake_src(slots[i].src2, wb_alu, wb_load);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            issue.valid <= 1'b0;
        end else begin
            issue.valid <= head_fire;
        end
        if (head_fire) begin
            issue.mem_op  <= slots[head].mem_op;
            issue.pc      <= slots[head].pc;
            issue.imm     <= slots[head].imm;
            issue.rs1     <= slots[head].src1.value;
            issue.rs2     <= slots[head].src2.value;
            issue.dst_tag <= slots[head].dst_tag;
        end
    end

endmodule

/* logic/issue_queue_ooo.sv */
`include "issue_defines.svh"

module issue_queue_ooo (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        flush,
    input  logic                        push,
    input  issue_types_pkg::dispatch_t  entry,
    input  issue_types_pkg::wb_bus_t    wb_alu,
    input  issue_types_pkg::wb_bus_t    wb_load,
    output logic                        full,
    output issue_types_pkg::alu_issue_t issue
);
    import issue_ops_pkg::*;
    import issue_types_pkg::*;

    localparam int DEPTH = `ISSUE_ALU_QUEUE_DEPTH;
    localparam int IDX_W = $clog2(DEPTH);

    typedef struct packed {
        alu_op_e  alu_op;
        pc_t      pc;
        word_t    imm;
        rob_tag_t dst_tag;
        src_t     src1;
        src_t     src2;
    } alu_slot_t;

    alu_slot_t              slots [DEPTH];
    alu_slot_t              incoming;
    logic [DEPTH-1:0]       valid;
    logic [DEPTH-1:0]       ready;
    logic [IDX_W-1:0]       free_idx;
    logic [IDX_W-1:0]       sel_idx;
    logic                   sel_any;

    // incoming operands also see this cycle's writebacks
    always_comb begin
        incoming.alu_op  = entry.alu_op;
        incoming.pc      = entry.pc;
        incoming.imm     = entry.imm;
        incoming.dst_tag = entry.dst_tag;
        incoming.src1    = wake_src(resolved_src(entry.src1), wb_alu, wb_load);
        incoming.src2    = wake_src(resolved_src(entry.src2), wb_alu, wb_load);
    end

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            ready[i] = valid[i] && !slots[i].src1.pending && !slots[i].src2.pending;
        end
    end

    // lowest index wins for both free slot and issue pick
    always_comb begin
        free_idx = '0;
        sel_idx  = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (!valid[i]) begin
                free_idx = IDX_W'(i);
            end
            if (ready[i]) begin
                sel_idx = IDX_W'(i);
            end
        end
    end

    assign sel_any = |ready;
    assign full    = &valid;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            valid <= '0;
        end else begin
            if (sel_any) begin
                valid[sel_idx] <= 1'b0;
            end
            if (push) begin
                valid[free_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            if (push && free_idx == IDX_W'(i)) begin
                slots[i] <= incoming;
            end else begin
                slots[i].src1 <= wake_src(slots[i].src1, wb_alu, wb_load);
                slots[i].src2 <= wake_src(slots[i].src2, wb_alu, wb_load);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            issue.valid <= 1'b0;
        end else begin
            issue.valid <= sel_any;
        end
        if (sel_any) begin
            issue.alu_op  <= slots[sel_idx].alu_op;
            issue.pc      <= slots[sel_idx].pc;
            issue.imm     <= slots[sel_idx].imm;
            issue.rs1     <= slots[sel_idx].src1.value;
            issue.rs2     <= slots[sel_idx].src2.value;
            issue.dst_tag <= slots[sel_idx].dst_tag;
        end
    end

    a_no_push_full: assert property (@(posedge clk) disable iff (reset) push |-> !full)
        else $error("alu queue pushed while full");

endmodule

/* logic/issue_stage.sv */
module issue_stage (
    input  logic                        clk,
    input  logic                        reset,
    input  issue_types_pkg::dispatch_t  dispatch,
    input  issue_types_pkg::wb_bus_t    wb_alu,
    input  issue_types_pkg::wb_bus_t    wb_load,
    input  logic                        rob_commit_br_taken,
    input  logic                        rob_commit_exp_en,
    input  logic                        mem_ready,
    output issue_types_pkg::alu_issue_t alu_issue,
    output issue_types_pkg::mem_issue_t mem_issue,
    output logic                        stall
);
    import issue_types_pkg::*;

    dispatch_t entry;
    logic      alu_push;
    logic      mem_push;
    logic      alu_full;
    logic      mem_full;
    logic      flush;

    // taken branch or exception at commit drops everything queued
    assign flush = rob_commit_br_taken || rob_commit_exp_en;

    dispatch_steer u_dispatch_steer (
        .dispatch (dispatch),
        .alu_full (alu_full),
        .mem_full (mem_full),
        .alu_push (alu_push),
        .mem_push (mem_push),
        .entry    (entry),
        .stall    (stall)
    );

    issue_queue_ooo u_alu_queue (
        .clk     (clk),
        .reset   (reset),
        .flush   (flush),
        .push    (alu_push),
        .entry   (entry),
        .wb_alu  (wb_alu),
        .wb_load (wb_load),
        .full    (alu_full),
        .issue   (alu_issue)
    );

    issue_queue_ino u_mem_queue (
        .clk       (clk),
        .reset     (reset),
        .flush     (flush),
        .push      (mem_push),
        .entry     (entry),
        .wb_alu    (wb_alu),
        .wb_load   (wb_load),
        .mem_ready (mem_ready),
        .full      (mem_full),
        .issue     (mem_issue)
    );

endmodule

/* logic/issue_types_pkg.sv */
`include "issue_defines.svh"

package issue_types_pkg;
    import issue_ops_pkg::*;

    typedef logic [`ISSUE_WORD_WIDTH-1:0]        word_t;
    typedef logic [`ISSUE_PC_WIDTH-1:0]          pc_t;
    typedef logic [$clog2(`ISSUE_ROB_DEPTH)-1:0] rob_tag_t;

    // operand as held in a queue
    typedef struct packed {
        logic     pending;
        rob_tag_t tag;
        word_t    value;
    } src_t;

    // raw source from rat, rob and gpr
    // once steered, rat_valid marks pending and gpr_value holds the operand
    typedef struct packed {
        logic     rat_valid;
        rob_tag_t tag;
        logic     rob_valid;
        word_t    rob_value;
        word_t    gpr_value;
    } dispatch_src_t;

    typedef struct packed {
        alu_op_e       alu_op;
        mem_op_e       mem_op;
        pc_t           pc;
        word_t         imm;
        rob_tag_t      dst_tag;
        dispatch_src_t src1;
        dispatch_src_t src2;
    } dispatch_t;

    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        word_t    value;
    } wb_bus_t;

    typedef struct packed {
        logic     valid;
        alu_op_e  alu_op;
        pc_t      pc;
        word_t    imm;
        word_t    rs1;
        word_t    rs2;
        rob_tag_t dst_tag;
    } alu_issue_t;

    typedef struct packed {
        logic     valid;
        mem_op_e  mem_op;
        pc_t      pc;
        word_t    imm;
        word_t    rs1;
        word_t    rs2;
        rob_tag_t dst_tag;
    } mem_issue_t;

    function automatic src_t resolved_src(dispatch_src_t d);
        src_t s;
        s.pending = d.rat_valid;
        s.tag     = d.tag;
        s.value   = d.gpr_value;
        return s;
    endfunction

    // alu bus first when both carry the tag
    function automatic src_t wake_src(src_t s, wb_bus_t a, wb_bus_t b);
        src_t r;
        r = s;
        if (s.pending && a.valid && a.tag == s.tag) begin
            r.pending = 1'b0;
            r.value   = a.value;
        end else if (s.pending && b.valid && b.tag == s.tag) begin
            r.pending = 1'b0;
            r.value   = b.value;
        end
        return r;
    endfunction

endpackage

/* logic/queue_pointers.sv */
module queue_pointers #(
    parameter int DEPTH = 4
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     flush,
    input  logic                     push,
    input  logic                     pop,
    output logic [$clog2(DEPTH)-1:0] head,
    output logic [$clog2(DEPTH)-1:0] tail,
    output logic                     full,
    output logic                     empty
);
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [CNT_W-1:0] count;

    function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tail <= next_ptr(tail);
            end
            if (pop) begin
                head <= next_ptr(head);
            end
            // push and pop together leave occupancy alone
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    assign full  = count == CNT_W'(DEPTH);
    assign empty = count == '0;

    a_no_pop_empty: assert property (@(posedge clk) disable iff (reset) pop |-> !empty)
        else $error("pop from empty queue");

endmodule

/* project.f */
+incdir+include
logic/issue_ops_pkg.sv
logic/issue_types_pkg.sv
logic/dispatch_steer.sv
logic/queue_pointers.sv
logic/issue_queue_ooo.sv
logic/issue_queue_ino.sv
logic/issue_stage.sv
sim/tb_issue_stage.sv

/* sim/tb_issue_stage.sv */
module tb_issue_stage;
    timeunit 1ns;
    timeprecision 1ps;
    import issue_ops_pkg::*;
    import issue_types_pkg::*;

    logic        clk;
    logic        reset;
    dispatch_t   dispatch;
    wb_bus_t     wb_alu;
    wb_bus_t     wb_load;
    logic        rob_commit_br_taken;
    logic        rob_commit_exp_en;
    logic        mem_ready;
    alu_issue_t  alu_issue;
    mem_issue_t  mem_issue;
    logic        stall;

    // expected alu issues by destination tag and memory issues in dispatch order
    alu_issue_t  alu_exp [16];
    logic [15:0] alu_live;
    mem_issue_t  mem_exp [8];
    logic [2:0]  mem_wr;
    logic [2:0]  mem_rd;
    logic        idle;
    logic        quiet;
    logic        prompt;
    logic        stall_chk;
    logic        exp_stall;
    int          errors;
    int          tests;
    int          test_base;
    int unsigned rng_state;

    issue_stage issue_stage_inst (
        .clk                 (clk),
        .reset               (reset),
        .dispatch            (dispatch),
        .wb_alu              (wb_alu),
        .wb_load             (wb_load),
        .rob_commit_br_taken (rob_commit_br_taken),
        .rob_commit_exp_en   (rob_commit_exp_en),
        .mem_ready           (mem_ready),
        .alu_issue           (alu_issue),
        .mem_issue           (mem_issue),
        .stall               (stall)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic flag_error(input string msg);
        errors++;
        $display("[ERROR] %0t: %s", $time, msg);
    endtask

    a_idle: assert property (@(posedge clk) disable iff (reset)
        idle |-> !alu_issue.valid && !mem_issue.valid && !stall)
        else flag_error("activity before first dispatch");
    a_quiet: assert property (@(posedge clk) disable iff (reset)
        quiet |-> !alu_issue.valid && !mem_issue.valid && !stall)
        else flag_error("issue or stall after flush");
    a_alu_value: assert property (@(posedge clk) disable iff (reset)
        alu_issue.valid |-> alu_live[alu_issue.dst_tag] && alu_issue == alu_exp[alu_issue.dst_tag])
        else flag_error("unexpected alu issue");
    a_alu_prompt: assert property (@(posedge clk) disable iff (reset)
        prompt |-> ##2 alu_issue.valid ##1 !alu_issue.valid)
        else flag_error("alu issue not one cycle after write");
    a_mem_order: assert property (@(posedge clk) disable iff (reset)
        mem_issue.valid |-> mem_rd != mem_wr && mem_issue == mem_exp[mem_rd])
        else flag_error("memory issue out of order or wrong");
    a_mem_ready: assert property (@(posedge clk) disable iff (reset)
        mem_issue.valid |-> $past(mem_ready))
        else flag_error("memory issue while not ready");
    a_stall: assert property (@(posedge clk) disable iff (reset)
        stall_chk |-> stall == exp_stall)
        else flag_error($sformatf("stall is %0b", stall));

    // retire expectations as issues appear
    always @(posedge clk) begin
        if (!reset && alu_issue.valid) begin
            alu_live[alu_issue.dst_tag] <= 1'b0;
        end
        if (!reset && mem_issue.valid && mem_rd != mem_wr) begin
            mem_rd <= mem_rd + 1'b1;
        end
    end

    function automatic word_t next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // forwarded sources set rat_valid too, so the rob value must win
    function automatic dispatch_src_t ready_src(logic fwd);
        dispatch_src_t s;
        s.rat_valid = fwd;
        s.rob_valid = fwd;
        s.tag       = rob_tag_t'(next_rand());
        s.rob_value = next_rand();
        s.gpr_value = next_rand();
        return s;
    endfunction

    function automatic dispatch_src_t pending_src(rob_tag_t tag);
        dispatch_src_t s;
        s           = ready_src(1'b0);
        s.rat_valid = 1'b1;
        s.tag       = tag;
        return s;
    endfunction

    function automatic word_t operand_value(dispatch_src_t s);
        return s.rob_valid ? s.rob_value : s.gpr_value;
    endfunction

    task automatic abort_run(string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $finish;
    endtask

    task automatic dispatch_op(input alu_op_e aop, input mem_op_e mop, input rob_tag_t dst,
                               input dispatch_src_t s1, input dispatch_src_t s2,
                               input word_t rs1_exp, input word_t rs2_exp, input logic accepted,
                               input logic chk_prompt, input logic chk_stall, input logic stall_val);
        dispatch_t  d;
        alu_issue_t ea;
        mem_issue_t em;
        d.alu_op  = aop;
        d.mem_op  = mop;
        d.pc      = next_rand();
        d.imm     = next_rand();
        d.dst_tag = dst;
        d.src1    = s1;
        d.src2    = s2;
        ea = '{1'b1, aop, d.pc, d.imm, rs1_exp, rs2_exp, dst};
        em = '{1'b1, mop, d.pc, d.imm, rs1_exp, rs2_exp, dst};
        @(posedge clk);
        dispatch  <= d;
        idle      <= 1'b0;
        quiet     <= 1'b0;
        prompt    <= chk_prompt;
        stall_chk <= chk_stall;
        exp_stall <= stall_val;
        if (accepted && aop != ALU_OP_NOP) begin
            alu_exp[dst]  = ea;
            alu_live[dst] <= 1'b1;
        end else if (accepted) begin
            mem_exp[mem_wr] = em;
            mem_wr <= mem_wr + 1'b1;
        end
        @(posedge clk);
        dispatch  <= '0;
        prompt    <= 1'b0;
        stall_chk <= 1'b0;
    endtask

    task automatic writeback(input logic load_bus, input rob_tag_t tag, input word_t value);
        @(posedge clk);
        if (load_bus) begin
            wb_load <= '{1'b1, tag, value};
        end else begin
            wb_alu <= '{1'b1, tag, value};
        end
        @(posedge clk);
        wb_alu  <= '0;
        wb_load <= '0;
    endtask

    task automatic wait_alu(input rob_tag_t tag);
        int n;
        n = 0;
        while (alu_live[tag]) begin
            @(posedge clk);
            n++;
            if (n > 60) begin
                abort_run($sformatf("timeout waiting for alu issue of tag %0d", tag));
            end
        end
    endtask

    task automatic wait_mem();
        int n;
        n = 0;
        while (mem_rd != mem_wr) begin
            @(posedge clk);
            n++;
            if (n > 60) begin
                abort_run("timeout waiting for the memory queue to drain");
            end
        end
    endtask

    task automatic report_test(input string name);
        tests++;
        $display("test %0d %s: %0d errors", tests, name, errors - test_base);
        test_base = errors;
    endtask

    initial begin
        word_t         v;
        dispatch_src_t s1;
        dispatch_src_t s2;
        reset = 1'b1;
        dispatch = '0;
        wb_alu = '0;
        wb_load = '0;
        rob_commit_br_taken = 1'b0;
        rob_commit_exp_en = 1'b0;
        mem_ready = 1'b1;
        alu_live = '0;
        mem_wr = '0;
        mem_rd = '0;
        idle = 1'b1;
        quiet = 1'b0;
        prompt = 1'b0;
        stall_chk = 1'b0;
        exp_stall = 1'b0;
        errors = 0;
        tests = 0;
        test_base = 0;
        rng_state = 91;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        repeat (4) @(posedge clk);
        report_test("reset idle");

        for (int i = 0; i < 3; i++) begin
            s1 = ready_src(1'b1);
            s2 = ready_src(i[0]);
            dispatch_op(alu_op_e'(i + 1), MEM_OP_NOP, rob_tag_t'(i + 1), s1, s2,
                        operand_value(s1), operand_value(s2), 1'b1, 1'b1, 1'b0, 1'b0);
            wait_alu(rob_tag_t'(i + 1));
        end
        report_test("alu ready operands");

        // older waits on tag 5 while a younger one passes it
        v  = next_rand();
        s2 = ready_src(1'b0);
        dispatch_op(ALU_OP_SUB, MEM_OP_NOP, 6, pending_src(5), s2, v, operand_value(s2),
                    1'b1, 1'b0, 1'b0, 1'b0);
        s1 = ready_src(1'b1);
        dispatch_op(ALU_OP_XOR, MEM_OP_NOP, 7, s1, s2, operand_value(s1), operand_value(s2),
                    1'b1, 1'b0, 1'b0, 1'b0);
        wait_alu(7);
        writeback(1'b0, 5, v);
        wait_alu(6);
        v = next_rand();
        dispatch_op(ALU_OP_ADDI, MEM_OP_NOP, 8, pending_src(12), s2, v, operand_value(s2),
                    1'b1, 1'b0, 1'b0, 1'b0);
        writeback(1'b1, 12, v);
        wait_alu(8);
        report_test("alu wakeup");

        @(posedge clk);
        mem_ready <= 1'b0;
        s1 = ready_src(1'b1);
        s2 = ready_src(1'b0);
        dispatch_op(ALU_OP_NOP, MEM_OP_LW, 2, s1, s2, operand_value(s1), operand_value(s2),
                    1'b1, 1'b0, 1'b0, 1'b0);
        dispatch_op(ALU_OP_NOP, MEM_OP_SW, 3, s2, s1, operand_value(s2), operand_value(s1),
                    1'b1, 1'b0, 1'b0, 1'b0);
        repeat (6) @(posedge clk);
        mem_ready <= 1'b1;
        wait_mem();
        v = next_rand();
        dispatch_op(ALU_OP_NOP, MEM_OP_LB, 4, pending_src(4), s2, v, operand_value(s2),
                    1'b1, 1'b0, 1'b0, 1'b0);
        dispatch_op(ALU_OP_NOP, MEM_OP_SB, 5, s1, s2, operand_value(s1), operand_value(s2),
                    1'b1, 1'b0, 1'b0, 1'b0);
        repeat (6) @(posedge clk);
        writeback(1'b1, 4, v);
        wait_mem();
        report_test("memory order");

        v = next_rand();
        for (int i = 9; i < 13; i++) begin
            dispatch_op(ALU_OP_AND, MEM_OP_NOP, rob_tag_t'(i), pending_src(9), s2, v,
                        operand_value(s2), 1'b1, 1'b0, 1'b1, 1'b0);
        end
        dispatch_op(ALU_OP_OR, MEM_OP_NOP, 13, s1, s2, '0, '0, 1'b0, 1'b0, 1'b1, 1'b1);
        dispatch_op(ALU_OP_NOP, MEM_OP_LH, 13, s1, s2, operand_value(s1), operand_value(s2),
                    1'b1, 1'b0, 1'b1, 1'b0);
        wait_mem();
        writeback(1'b0, 9, v);
        for (int i = 9; i < 13; i++) begin
            wait_alu(rob_tag_t'(i));
        end
        report_test("full queue stall");

        for (int k = 0; k < 2; k++) begin
            // a full alu queue stalls until the flush empties it
            for (int j = 0; j < 4; j++) begin
                dispatch_op(ALU_OP_SLT, MEM_OP_NOP, 14, pending_src(14), s2, '0, '0,
                            1'b0, 1'b0, 1'b0, 1'b0);
            end
            dispatch_op(ALU_OP_SLT, MEM_OP_NOP, 14, pending_src(14), s2, '0, '0,
                        1'b0, 1'b0, 1'b1, 1'b1);
            dispatch_op(ALU_OP_NOP, MEM_OP_LBU, 14, pending_src(14), s2, '0, '0,
                        1'b0, 1'b0, 1'b0, 1'b0);
            @(posedge clk);
            rob_commit_br_taken <= (k == 0);
            rob_commit_exp_en   <= (k == 1);
            @(posedge clk);
            rob_commit_br_taken <= 1'b0;
            rob_commit_exp_en   <= 1'b0;
            quiet               <= 1'b1;
            writeback(1'b0, 14, next_rand());
            repeat (4) @(posedge clk);
            dispatch_op(ALU_OP_SRA, MEM_OP_NOP, 15, s1, s2, operand_value(s1),
                        operand_value(s2), 1'b1, 1'b1, 1'b1, 1'b0);
            wait_alu(15);
        end
        report_test("flush");

        repeat (4) @(posedge clk);
        $display("tests %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
